// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_rapcore -o tb_rapcore \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_rapcore +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/command_sequencer.sv
`default_nettype none

module command_sequencer (
  input  logic CLK,
  input  logic resetn,
  input  rapcore_pkg::spi_frame_t frame,
  input  logic frame_valid,
  output logic [rapcore_pkg::word_w-1:0] reply,
  output logic reply_load,
  output rapcore_pkg::bus_req_t bus,
  input  logic grant,
  input  logic [rapcore_pkg::word_w-1:0] rdata,
  output logic move_start
);

  logic [rapcore_pkg::addr_w-1:0] frame_addr;
  logic host_writable;
  logic read_done;
  logic zero_load;  // Reply of zero for everything but reads

  assign frame_addr = frame.addr[rapcore_pkg::addr_w-1:0];

  // Position, encoder and the unused words are read-only from the host
  assign host_writable = frame_addr <= rapcore_pkg::reg_scratch;

  assign read_done = bus.req && !bus.we && grant;
  assign reply_load = read_done || zero_load;
  assign reply = read_done ? rdata : '0;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bus <= '0;
      zero_load <= 1'b0;
      move_start <= 1'b0;
    end else begin
      zero_load <= 1'b0;
      move_start <= 1'b0;
      if (bus.req && grant)
        bus.req <= 1'b0;  // Access done
      if (frame_valid && !bus.req) begin
        case (frame.opcode)
          rapcore_pkg::op_write: begin
            zero_load <= 1'b1;
            if (host_writable) begin
              bus <= '{req: 1'b1, we: 1'b1, addr: frame_addr, wdata: frame.data};
            end
          end
          rapcore_pkg::op_read: begin
            bus <= '{req: 1'b1, we: 1'b0, addr: frame_addr, wdata: '0};
          end
          rapcore_pkg::op_move: begin
            zero_load <= 1'b1;
            move_start <= 1'b1;
          end
          default: begin
            zero_load <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: source/quad_encoder.sv
`default_nettype none

module quad_encoder (
  input  logic CLK,
  input  logic resetn,
  input  logic enc_a,
  input  logic enc_b,
  output rapcore_pkg::bus_req_t bus
);

  logic [2:0] a_q;  // Two sync stages plus previous level
  logic [2:0] b_q;
  logic [3:0] trans;
  logic signed [rapcore_pkg::word_w-1:0] count;
  logic signed [rapcore_pkg::word_w-1:0] count_next;

  assign trans = {a_q[2], b_q[2], a_q[1], b_q[1]};  // Previous AB, current AB

  // Forward Gray order is 00, 10, 11, 01
  always_comb begin
    case (trans)
      4'b0010, 4'b1011, 4'b1101, 4'b0100: count_next = count + 32'sd1;
      4'b1000, 4'b1110, 4'b0111, 4'b0001: count_next = count - 32'sd1;
      default: count_next = count;  // No change or double change
    endcase
  end

  // Highest priority, so each posted write lands in its own cycle
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q <= '0;
      b_q <= '0;
      count <= '0;
      bus <= '0;
    end else begin
      a_q <= {a_q[1:0], enc_a};
      b_q <= {b_q[1:0], enc_b};
      count <= count_next;
      bus <= '{
        req: count_next != count,
        we: 1'b1,
        addr: rapcore_pkg::reg_enc,
        wdata: count_next
      };
    end
  end

endmodule

`default_nettype wire

// File: source/rapcore_lite.sv
`default_nettype none

module rapcore_lite (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic ENC_A,
  input  logic ENC_B,
  output logic STEP,
  output logic DIR,
  output logic ENABLE,
  output logic MOVE_DONE
);

  rapcore_pkg::spi_frame_t frame;
  logic frame_valid;
  logic [rapcore_pkg::word_w-1:0] reply;
  logic reply_load;
  logic move_start;

  // Shared register bus
  rapcore_pkg::bus_req_t req [rapcore_pkg::rq_count];
  logic [rapcore_pkg::rq_count-1:0] grant;
  logic [rapcore_pkg::word_w-1:0] rdata;

  spi_target i_spi_target (
    .CLK(CLK),
    .resetn(resetn),
    .SCK(SCK),
    .CS(CS),
    .COPI(COPI),
    .CIPO(CIPO),
    .frame(frame),
    .frame_valid(frame_valid),
    .reply(reply),
    .reply_load(reply_load)
  );

  command_sequencer i_command_sequencer (
    .CLK(CLK),
    .resetn(resetn),
    .frame(frame),
    .frame_valid(frame_valid),
    .reply(reply),
    .reply_load(reply_load),
    .bus(req[rapcore_pkg::rq_cmd]),
    .grant(grant[rapcore_pkg::rq_cmd]),
    .rdata(rdata),
    .move_start(move_start)
  );

  reg_arbiter i_reg_arbiter (
    .CLK(CLK),
    .resetn(resetn),
    .req(req),
    .grant(grant),
    .rdata(rdata)
  );

  step_generator i_step_generator (
    .CLK(CLK),
    .resetn(resetn),
    .move_start(move_start),
    .bus(req[rapcore_pkg::rq_step]),
    .grant(grant[rapcore_pkg::rq_step]),
    .rdata(rdata),
    .step(STEP),
    .dir(DIR),
    .enable(ENABLE),
    .move_done(MOVE_DONE)
  );

  quad_encoder i_quad_encoder (
    .CLK(CLK),
    .resetn(resetn),
    .enc_a(ENC_A),
    .enc_b(ENC_B),
    .bus(req[rapcore_pkg::rq_enc])
  );

endmodule

`default_nettype wire

// File: source/rapcore_pkg.sv
`default_nettype none

package rapcore_pkg;

  localparam int word_w = 32;
  localparam int frame_w = 40;
  localparam int reg_count = 8;
  localparam int addr_w = 3;
  localparam int rq_count = 3;

  // Register map
  localparam logic [addr_w-1:0] reg_period = 3'd0;  // Clocks per STEP half period
  localparam logic [addr_w-1:0] reg_steps = 3'd1;
  localparam logic [addr_w-1:0] reg_ctrl = 3'd2;  // Bit 0 dir, bit 1 enable
  localparam logic [addr_w-1:0] reg_scratch = 3'd3;
  localparam logic [addr_w-1:0] reg_pos = 3'd4;
  localparam logic [addr_w-1:0] reg_enc = 3'd5;

  // Arbiter ports, lowest index wins
  localparam int rq_enc = 0;
  localparam int rq_step = 1;
  localparam int rq_cmd = 2;

  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_write = 4'd1,
    op_read  = 4'd2,
    op_move  = 4'd3
  } opcode_e;

  typedef enum logic [2:0] {
    s_idle,
    s_fetch_period,
    s_fetch_steps,
    s_fetch_ctrl,
    s_high,
    s_low,
    s_post
  } move_state_e;

  // SPI command frame, MSB first on the wire
  typedef struct packed {
    opcode_e opcode;
    logic [3:0] addr;
    logic [word_w-1:0] data;
  } spi_frame_t;

  typedef struct packed {
    logic req;
    logic we;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
  } bus_req_t;

endpackage

`default_nettype wire

// File: source/reg_arbiter.sv
`default_nettype none

module reg_arbiter (
  input  logic CLK,
  input  logic resetn,
  input  rapcore_pkg::bus_req_t req [rapcore_pkg::rq_count],
  output logic [rapcore_pkg::rq_count-1:0] grant,
  output logic [rapcore_pkg::word_w-1:0] rdata
);

  logic [rapcore_pkg::word_w-1:0] regs [rapcore_pkg::reg_count];
  rapcore_pkg::bus_req_t sel;  // Winning request

  // Fixed priority, lowest index first
  always_comb begin
    grant = '0;
    sel = '0;
    for (int i = 0; i < rapcore_pkg::rq_count; i++) begin
      if (req[i].req && grant == '0) begin
        grant[i] = 1'b1;
        sel = req[i];
      end
    end
  end

  assign rdata = regs[sel.addr];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      for (int i = 0; i < rapcore_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (sel.req && sel.we) begin
      regs[sel.addr] <= sel.wdata;
    end
  end

endmodule

`default_nettype wire

// File: source/spi_target.sv
`default_nettype none

module spi_target (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  output rapcore_pkg::spi_frame_t frame,
  output logic frame_valid,
  input  logic [rapcore_pkg::word_w-1:0] reply,
  input  logic reply_load
);

  logic [2:0] sck_q;  // Two sync stages plus edge history
  logic [1:0] cs_q;
  logic [1:0] copi_q;
  logic sck_rise;
  logic sck_fall;
  logic last_bit;
  logic reply_phase;
  logic [5:0] bit_cnt;
  logic [1:0] done_q;
  logic [rapcore_pkg::frame_w-1:0] rx_sr;
  logic [rapcore_pkg::word_w-1:0] reply_q;
  logic [rapcore_pkg::word_w-1:0] tx_sr;

  assign sck_rise = sck_q[1] && !sck_q[2];
  assign sck_fall = !sck_q[1] && sck_q[2];
  assign last_bit = sck_rise && !cs_q[1] && (bit_cnt == 6'(rapcore_pkg::frame_w - 1));

  // Reply sits in the last word_w bits of the frame
  assign reply_phase = (bit_cnt >= 6'(rapcore_pkg::frame_w - rapcore_pkg::word_w)) &&
                       (bit_cnt < 6'(rapcore_pkg::frame_w));

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q <= '0;
      cs_q <= '1;
      copi_q <= '0;
      bit_cnt <= '0;
      done_q <= '0;
      frame_valid <= 1'b0;
      reply_q <= '0;
      CIPO <= 1'b0;
    end else begin
      sck_q <= {sck_q[1:0], SCK};
      cs_q <= {cs_q[0], CS};
      copi_q <= {copi_q[0], COPI};
      done_q <= {done_q[0], last_bit};
      frame_valid <= done_q[1];
      if (reply_load)
        reply_q <= reply;
      if (cs_q[1]) begin  // Deselected, short frames are lost here
        bit_cnt <= '0;
        CIPO <= 1'b0;
      end else if (sck_rise && bit_cnt != 6'(rapcore_pkg::frame_w)) begin
        bit_cnt <= bit_cnt + 6'd1;
      end else if (sck_fall) begin
        CIPO <= reply_phase && tx_sr[rapcore_pkg::word_w-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!reply_phase)
      tx_sr <= reply_q;
    else if (sck_fall)
      tx_sr <= {tx_sr[rapcore_pkg::word_w-2:0], 1'b0};
    if (sck_rise)
      rx_sr <= {rx_sr[rapcore_pkg::frame_w-2:0], copi_q[1]};
    if (done_q[1])
      frame <= rapcore_pkg::spi_frame_t'(rx_sr);
  end

endmodule

`default_nettype wire

// File: source/step_generator.sv
`default_nettype none

module step_generator (
  input  logic CLK,
  input  logic resetn,
  input  logic move_start,
  output rapcore_pkg::bus_req_t bus,
  input  logic grant,
  input  logic [rapcore_pkg::word_w-1:0] rdata,
  output logic step,
  output logic dir,
  output logic enable,
  output logic move_done
);

  rapcore_pkg::move_state_e state;
  logic [rapcore_pkg::word_w-1:0] period_q;
  logic [rapcore_pkg::word_w-1:0] steps_q;  // Steps still to go
  logic [rapcore_pkg::word_w-1:0] cnt;
  logic signed [rapcore_pkg::word_w-1:0] position;
  logic signed [rapcore_pkg::word_w-1:0] pos_next;

  assign pos_next = dir ? position + 32'sd1 : position - 32'sd1;

  always_comb begin
    case (state)
      rapcore_pkg::s_fetch_period:
        bus = '{req: 1'b1, we: 1'b0, addr: rapcore_pkg::reg_period, wdata: '0};
      rapcore_pkg::s_fetch_steps:
        bus = '{req: 1'b1, we: 1'b0, addr: rapcore_pkg::reg_steps, wdata: '0};
      rapcore_pkg::s_fetch_ctrl:
        bus = '{req: 1'b1, we: 1'b0, addr: rapcore_pkg::reg_ctrl, wdata: '0};
      rapcore_pkg::s_post:
        bus = '{req: 1'b1, we: 1'b1, addr: rapcore_pkg::reg_pos, wdata: pos_next};
      default:
        bus = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= rapcore_pkg::s_idle;
      period_q <= '0;
      steps_q <= '0;
      cnt <= '0;
      position <= '0;
      step <= 1'b0;
      dir <= 1'b0;
      enable <= 1'b0;
      move_done <= 1'b1;
    end else begin
      case (state)
        rapcore_pkg::s_idle: begin
          if (move_start) begin
            move_done <= 1'b0;
            state <= rapcore_pkg::s_fetch_period;
          end
        end
        rapcore_pkg::s_fetch_period: begin
          if (grant) begin
            period_q <= (rdata == '0) ? 32'd1 : rdata;  // Zero period runs as one
            state <= rapcore_pkg::s_fetch_steps;
          end
        end
        rapcore_pkg::s_fetch_steps: begin
          if (grant) begin
            steps_q <= rdata;
            state <= rapcore_pkg::s_fetch_ctrl;
          end
        end
        rapcore_pkg::s_fetch_ctrl: begin
          if (grant) begin
            dir <= rdata[0];
            enable <= rdata[1];
            if (steps_q == '0) begin
              move_done <= 1'b1;
              state <= rapcore_pkg::s_idle;
            end else begin
              step <= 1'b1;
              cnt <= period_q - 32'd1;
              state <= rapcore_pkg::s_high;
            end
          end
        end
        rapcore_pkg::s_high: begin
          if (cnt == '0) begin
            step <= 1'b0;
            cnt <= period_q - 32'd2;
            // The post cycle closes the low phase
            state <= (period_q == 32'd1) ? rapcore_pkg::s_post : rapcore_pkg::s_low;
          end else begin
            cnt <= cnt - 32'd1;
          end
        end
        rapcore_pkg::s_low: begin
          if (cnt == '0)
            state <= rapcore_pkg::s_post;
          else
            cnt <= cnt - 32'd1;
        end
        rapcore_pkg::s_post: begin
          if (grant) begin
            position <= pos_next;
            steps_q <= steps_q - 32'd1;
            if (steps_q == 32'd1) begin
              move_done <= 1'b1;
              state <= rapcore_pkg::s_idle;
            end else begin
              step <= 1'b1;
              cnt <= period_q - 32'd1;
              state <= rapcore_pkg::s_high;
            end
          end
        end
        default: state <= rapcore_pkg::s_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src.f
source/rapcore_pkg.sv
source/spi_target.sv
source/command_sequencer.sv
source/reg_arbiter.sv
source/step_generator.sv
source/quad_encoder.sv
source/rapcore_lite.sv
test/rapcore_sva.sv
test/tb_rapcore.sv

// File: test/rapcore_sva.sv
`default_nettype none

module rapcore_sva (
  input logic CLK,
  input logic resetn,
  input logic STEP,
  input logic DIR,
  input logic ENABLE,
  input logic MOVE_DONE,
  input logic CIPO,
  input logic [rapcore_pkg::rq_count-1:0] grant,
  input logic [rapcore_pkg::rq_count-1:0] req_active,
  input logic [rapcore_pkg::word_w-1:0] period
);

  int fail_count = 0;
  logic [rapcore_pkg::word_w-1:0] high_cnt;  // Length of the current STEP pulse

  always_ff @(posedge CLK) begin
    if (!resetn || !STEP)
      high_cnt <= '0;
    else
      high_cnt <= high_cnt + 32'd1;
  end

  // First cycle out of reset
  reset_state: assert property (@(posedge CLK) $rose(resetn) |->
      !STEP && !DIR && !ENABLE && MOVE_DONE && !CIPO && req_active == '0)
    else begin
      $error("Outputs or requests not at their reset values");
      fail_count++;
    end

  grant_onehot: assert property (@(posedge CLK) disable iff (!resetn) $onehot0(grant))
    else begin
      $error("More than one grant high");
      fail_count++;
    end

  grant_has_req: assert property (@(posedge CLK) disable iff (!resetn)
      (grant & ~req_active) == '0)
    else begin
      $error("Grant given without a request");
      fail_count++;
    end

  // A programmed period of zero runs as one
  step_width: assert property (@(posedge CLK) disable iff (!resetn)
      $fell(STEP) |-> high_cnt == ((period == '0) ? 32'd1 : period))
    else begin
      $error("STEP pulse width differs from the period");
      fail_count++;
    end

endmodule

bind rapcore_lite rapcore_sva i_rapcore_sva (
  .CLK(CLK),
  .resetn(resetn),
  .STEP(STEP),
  .DIR(DIR),
  .ENABLE(ENABLE),
  .MOVE_DONE(MOVE_DONE),
  .CIPO(CIPO),
  .grant(grant),
  .req_active({req[rapcore_pkg::rq_cmd].req,
               req[rapcore_pkg::rq_step].req,
               req[rapcore_pkg::rq_enc].req}),
  .period(i_reg_arbiter.regs[rapcore_pkg::reg_period])
);

`default_nettype wire

// File: test/tb_rapcore.sv
`default_nettype none

module tb_rapcore;

  logic CLK = 1'b0;
  logic resetn;
  logic SCK;
  logic CS;
  logic COPI;
  logic CIPO;
  logic ENC_A;
  logic ENC_B;
  logic STEP;
  logic DIR;
  logic ENABLE;
  logic MOVE_DONE;

  logic [15:0] lfsr = 16'd97;
  int errors = 0;
  int mon_errors = 0;
  int cycles = 0;
  int step_rises = 0;
  int pos_sum = 0;  // Expected position
  logic step_prev = 1'b0;
  logic exp_dir = 1'b0;
  logic exp_en = 1'b0;
  logic [31:0] prev_reply = '0;  // Reply due during the next frame
  string prev_name = "CIPO reply after reset";

  rapcore_lite i_rapcore_lite (
    .CLK(CLK),
    .resetn(resetn),
    .SCK(SCK),
    .CS(CS),
    .COPI(COPI),
    .CIPO(CIPO),
    .ENC_A(ENC_A),
    .ENC_B(ENC_B),
    .STEP(STEP),
    .DIR(DIR),
    .ENABLE(ENABLE),
    .MOVE_DONE(MOVE_DONE)
  );

  always #20 CLK = ~CLK;

  // Worst case run is well under this
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles == 20000) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // Move monitor, samples between clock edges
  always @(negedge CLK) begin
    if (resetn) begin
      if (STEP && !step_prev)
        step_rises <= step_rises + 1;
      if (STEP) begin
        assert (DIR === exp_dir && ENABLE === exp_en && MOVE_DONE === 1'b0) else begin
          $display("[ERROR] %0t DIR,ENABLE,MOVE_DONE expected %b,%b,0 actual %b,%b,%b",
                   $time, exp_dir, exp_en, DIR, ENABLE, MOVE_DONE);
          mon_errors <= mon_errors + 1;
        end
      end
    end
    step_prev <= STEP;
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic rapcore_pkg::spi_frame_t make_frame(input rapcore_pkg::opcode_e op,
      input logic [rapcore_pkg::addr_w-1:0] addr, input logic [31:0] data);
    rapcore_pkg::spi_frame_t f;
    f.opcode = op;
    f.addr = 4'(addr);
    f.data = data;
    return f;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Mode 0 frame, 8 CLK per SCK period; checks the reply of the frame before
  task automatic spi_xfer(input rapcore_pkg::spi_frame_t f, input logic [31:0] reply_exp,
      input string name);
    logic [rapcore_pkg::frame_w-1:0] bits;
    logic [rapcore_pkg::frame_w-1:0] cap;
    bits = f;
    cap = '0;
    @(posedge CLK);
    CS <= 1'b0;
    for (int i = rapcore_pkg::frame_w - 1; i >= 0; i--) begin
      COPI <= bits[i];
      repeat (4) @(posedge CLK);
      SCK <= 1'b1;
      @(negedge CLK);
      cap = {cap[rapcore_pkg::frame_w-2:0], CIPO};
      repeat (4) @(posedge CLK);
      SCK <= 1'b0;
    end
    repeat (4) @(posedge CLK);
    CS <= 1'b1;
    check_value("CIPO lead bits", '0, 32'(cap[39:32]));
    check_value(prev_name, prev_reply, cap[31:0]);
    prev_reply = reply_exp;
    prev_name = name;
    repeat (6) @(posedge CLK);
  endtask

  task automatic write_reg(input logic [rapcore_pkg::addr_w-1:0] addr, input logic [31:0] data);
    spi_xfer(make_frame(rapcore_pkg::op_write, addr, data), '0, "CIPO reply to write");
  endtask

  task automatic read_reg(input logic [rapcore_pkg::addr_w-1:0] addr,
      input logic [31:0] expected, input string name);
    spi_xfer(make_frame(rapcore_pkg::op_read, addr, '0), expected, name);
  endtask

  task automatic start_move();
    spi_xfer(make_frame(rapcore_pkg::op_move, '0, '0), '0, "CIPO reply to move");
  endtask

  task automatic wait_move_done();
    @(negedge CLK);
    while (!MOVE_DONE)
      @(negedge CLK);
  endtask

  // Forward AB order is 10, 11, 01, 00
  task automatic enc_steps(input int n, input logic forward);
    logic [1:0] seq [4];
    if (forward)
      seq = '{2'b10, 2'b11, 2'b01, 2'b00};
    else
      seq = '{2'b01, 2'b11, 2'b10, 2'b00};
    for (int c = 0; c < n; c++) begin
      for (int k = 0; k < 4; k++) begin
        @(posedge CLK);
        {ENC_A, ENC_B} <= seq[k];
        repeat (7) @(posedge CLK);
      end
    end
  endtask

  task automatic run_move(input logic [31:0] period, input logic [31:0] steps,
      input logic [1:0] ctrl, input logic repeat_move, input int enc_fwd, input int enc_rev);
    int rises_before;
    write_reg(rapcore_pkg::reg_period, period);
    write_reg(rapcore_pkg::reg_steps, steps);
    write_reg(rapcore_pkg::reg_ctrl, {30'd0, ctrl});
    exp_dir = ctrl[0];
    exp_en = ctrl[1];
    rises_before = step_rises;
    start_move();
    if (repeat_move) begin
      @(negedge CLK);
      check_value("MOVE_DONE", '0, 32'(MOVE_DONE));
      start_move();  // Lands while busy
      @(negedge CLK);
      check_value("MOVE_DONE", '0, 32'(MOVE_DONE));
    end
    enc_steps(enc_fwd, 1'b1);
    enc_steps(enc_rev, 1'b0);
    wait_move_done();
    check_value("STEP rising edges", steps, 32'(step_rises - rises_before));
    pos_sum += ctrl[0] ? int'(steps) : -int'(steps);
  endtask

  initial begin
    logic [31:0] words [4];
    logic [31:0] period;
    logic [31:0] steps;
    int n_fwd;
    int n_rev;
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    ENC_A = 1'b0;
    ENC_B = 1'b0;
    repeat (4) @(posedge CLK);
    resetn <= 1'b1;
    repeat (2) @(posedge CLK);

    // Host words at addresses 0 to 3
    for (int i = 0; i < 4; i++) begin
      words[i] = lfsr_bits(32);
      write_reg(3'(i), words[i]);
    end
    for (int i = 0; i < 4; i++)
      read_reg(3'(i), words[i], "CIPO reply (register read)");
    read_reg(3'd6, '0, "CIPO reply (address 6)");
    read_reg(3'd7, '0, "CIPO reply (address 7)");

    write_reg(rapcore_pkg::reg_pos, lfsr_bits(32));
    write_reg(rapcore_pkg::reg_enc, lfsr_bits(32));
    read_reg(rapcore_pkg::reg_pos, '0, "CIPO reply (reg_pos)");
    read_reg(rapcore_pkg::reg_enc, '0, "CIPO reply (reg_enc)");

    for (int i = 0; i < 3; i++) begin
      period = lfsr_bits(3) + 32'd1;
      steps = lfsr_bits(5) % 32'd21;
      run_move(period, steps, 2'(lfsr_bits(2)), 1'b0, 0, 0);
    end
    run_move(32'd8, 32'd28, 2'(lfsr_bits(2)), 1'b1, 0, 0);
    run_move(32'd3, 32'd0, 2'b11, 1'b0, 0, 0);  // No pulses expected

    // Encoder turns while a move runs
    n_fwd = int'(lfsr_bits(2)) + 1;
    n_rev = int'(lfsr_bits(2));
    run_move(32'd6, 32'd12, 2'(lfsr_bits(2)), 1'b0, n_fwd, n_rev);
    read_reg(rapcore_pkg::reg_pos, 32'(pos_sum), "CIPO reply (reg_pos)");
    read_reg(rapcore_pkg::reg_enc, 32'(4 * (n_fwd - n_rev)), "CIPO reply (reg_enc)");
    spi_xfer(make_frame(rapcore_pkg::op_nop, '0, '0), '0, "CIPO reply to nop");

    $display("Errors: %0d checks, %0d monitor, %0d assertions", errors, mon_errors,
             i_rapcore_lite.i_rapcore_sva.fail_count);
    if (errors == 0 && mon_errors == 0 && i_rapcore_lite.i_rapcore_sva.fail_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
